//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath widths
    localparam int DATA_W     = 32;   // register and result width
    localparam int REG_ADDR_W = 5;    // 32 registers per bank
    localparam int IMM_W      = 18;   // immediate field, sign-extended to DATA_W
    localparam int OP_W       = 4;    // operation code width
    localparam int R_PAD_W    = 13;   // unused tail of a register-register word

    // operation codes, anything not listed here gives a zero result
    typedef enum logic [OP_W-1:0] {
        op_add   = 4'd0,   // rs1 + rs2
        op_sub   = 4'd1,   // rs1 - rs2
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_addi  = 4'd5,   // rs1 + imm
        op_loadi = 4'd6    // imm alone
    } alu_op_e;

    // register-register view of the instruction word
    typedef struct packed {
        alu_op_e               op;    // [31:28]
        logic [REG_ADDR_W-1:0] rd;    // [27:23]
        logic [REG_ADDR_W-1:0] rs1;   // [22:18]
        logic [REG_ADDR_W-1:0] rs2;   // [17:13]
        logic [R_PAD_W-1:0]    pad;   // [12:0] ignored
    } r_fmt_t;

    // register-immediate view, imm overlays rs2 and pad
    typedef struct packed {
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [IMM_W-1:0]      imm;   // two's complement
    } i_fmt_t;

    // one 32-bit word, decoded either way depending on op
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } exec_instr_u;

    // execute-stage record, registered in issue_ctrl
    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_imm;   // operand b comes from imm_ext
        logic [DATA_W-1:0]     imm_ext;
    } issue_t;

    // writeback to both banks, also the unit's result
    typedef struct packed {
        logic                  valid;   // bank write enable
        logic [REG_ADDR_W-1:0] rd;      // bank write address
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage

`default_nettype wire

//--- sdpram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual-port ram, one write port and one read port on a common clock
// read latency is one cycle, the array itself behaves read-first
// write_first mode patches a same-address write over the stale array output
module sdpram #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32,
    parameter     WRITE_MODE = "write_first"   // or "read_first"
) (
    input  wire logic                  clk,
    input  wire logic                  reset,

    input  wire logic                  en,      // shared enable for both ports
    input  wire logic                  we,
    input  wire logic [ADDR_WIDTH-1:0] raddr,
    input  wire logic [ADDR_WIDTH-1:0] waddr,
    input  wire logic [DATA_WIDTH-1:0] wdata,
    output logic      [DATA_WIDTH-1:0] rdata
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];   // contents undefined until written
    logic [DATA_WIDTH-1:0] dout;          // registered array output
    logic [DATA_WIDTH-1:0] din;           // copy of the last write data
    logic                  conflict;      // last read hit the address being written

    // array port, stands in for the vendor block ram
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            dout <= mem[raddr];   // old contents on a same-address write
        end
    end

    // conflict flag, held along with dout while en is low
    always_ff @(posedge clk) begin
        if (reset) begin
            conflict <= 1'b0;
        end else if (en) begin
            conflict <= we && (raddr == waddr);
        end
    end

    // payload only, follows the conflict flag
    always_ff @(posedge clk) begin
        if (en) begin
            din <= wdata;
        end
    end

    generate
        if (WRITE_MODE == "write_first") begin : g_write_first
            // new data wins when the read and the write met at the same edge
            assign rdata = conflict ? din : dout;
        end else begin : g_read_first
            assign rdata = dout;   // conflict and din are left unused here
        end
    endgenerate

endmodule

`default_nettype wire

//--- issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// front of the slice
// splits the instruction word into bank read addresses (combinational)
// and an execute-stage record registered for the following cycle
module issue_ctrl (
    input  wire logic                               clk,
    input  wire logic                               reset,

    input  wire logic                               instr_valid,
    input  wire exec_pkg::exec_instr_u              instr,
    input  wire logic                               wb_valid,   // write pending in the banks

    output logic      [exec_pkg::REG_ADDR_W-1:0]    raddr_a,
    output logic      [exec_pkg::REG_ADDR_W-1:0]    raddr_b,
    output logic                                    ram_en,
    output exec_pkg::issue_t                        issue
);

    // width of the sign fill above the immediate field
    localparam int EXT_W = exec_pkg::DATA_W - exec_pkg::IMM_W;

    exec_pkg::alu_op_e                op;         // op sits at the same bits in both views
    logic [exec_pkg::REG_ADDR_W-1:0]  rd;
    logic [exec_pkg::IMM_W-1:0]       imm;
    logic [exec_pkg::DATA_W-1:0]      imm_ext;
    logic                             use_imm;
    exec_pkg::issue_t                 issue_q;

    // field extraction from the union
    assign op  = instr.r.op;
    assign rd  = instr.r.rd;
    assign imm = instr.i.imm;       // only meaningful for the immediate forms

    // sign extension of the 18-bit immediate
    assign imm_ext = {{EXT_W{imm[exec_pkg::IMM_W-1]}}, imm};

    // immediate forms take operand b from the word, not from bank_b
    always_comb begin
        case (op)
            exec_pkg::op_addi,
            exec_pkg::op_loadi: use_imm = 1'b1;
            default:            use_imm = 1'b0;   // reg-reg and unused codes
        endcase
    end

    // read addresses go straight to the banks in the issue cycle
    // rs1 lines up in both views, rs2 only exists in the r view
    assign raddr_a = instr.r.rs1;
    assign raddr_b = instr.r.rs2;   // reads a don't-care register for i forms

    // banks share one enable, the write port needs it as well
    assign ram_en = instr_valid || wb_valid;

    // execute-stage record
    // only valid is cleared, the payload is loaded with each accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q.valid <= instr_valid;   // a bubble follows an idle cycle
        end
        if (instr_valid) begin
            issue_q.op      <= op;
            issue_q.rd      <= rd;
            issue_q.use_imm <= use_imm;
            issue_q.imm_ext <= imm_ext;
        end
    end

    assign issue = issue_q;

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

// execute stage, purely combinational
// operand a comes from bank_a, operand b from bank_b or the immediate
module alu (
    input  wire exec_pkg::issue_t                  issue,
    input  wire logic [exec_pkg::DATA_W-1:0]       opnd_a,   // rs1 value
    input  wire logic [exec_pkg::DATA_W-1:0]       opnd_b,   // rs2 value
    output exec_pkg::wb_t                          wb
);

    logic [exec_pkg::DATA_W-1:0] b_sel;   // second operand after the immediate mux
    logic [exec_pkg::DATA_W-1:0] res;

    // immediate forms ignore bank_b
    assign b_sel = issue.use_imm ? issue.imm_ext : opnd_b;

    always_comb begin
        case (issue.op)
            exec_pkg::op_add:   res = opnd_a + b_sel;
            exec_pkg::op_sub:   res = opnd_a - b_sel;   // wraps mod 2^32
            exec_pkg::op_and:   res = opnd_a & b_sel;
            exec_pkg::op_or:    res = opnd_a | b_sel;
            exec_pkg::op_xor:   res = opnd_a ^ b_sel;
            exec_pkg::op_addi:  res = opnd_a + b_sel;   // b_sel holds imm here
            exec_pkg::op_loadi: res = b_sel;            // rs1 is not used
            default:            res = '0;               // unused codes still write rd
        endcase
    end

    // writeback record, valid doubles as the bank write enable
    assign wb.valid = issue.valid;
    assign wb.rd    = issue.rd;
    assign wb.data  = res;

endmodule

`default_nettype wire

//--- reg_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

// register-file execute slice
// issue_ctrl -> two register banks (one per read port) -> alu -> writeback
// a dependent instruction on the next cycle sees the new value
// through the bank write-first bypass
module reg_exec_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,

    input  wire logic                   instr_valid,
    input  wire exec_pkg::exec_instr_u  instr,
    output exec_pkg::wb_t               result
);

    logic [exec_pkg::REG_ADDR_W-1:0] raddr_a;
    logic [exec_pkg::REG_ADDR_W-1:0] raddr_b;
    logic                            ram_en;
    exec_pkg::issue_t                issue;
    logic [exec_pkg::DATA_W-1:0]     rdata_a;   // rs1 operand
    logic [exec_pkg::DATA_W-1:0]     rdata_b;   // rs2 operand
    exec_pkg::wb_t                   wb;

    issue_ctrl u_issue_ctrl (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb.valid),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .ram_en      (ram_en),
        .issue       (issue)
    );

    // both copies take every writeback so they always hold the same contents
    sdpram #(
        .ADDR_WIDTH (exec_pkg::REG_ADDR_W),
        .DATA_WIDTH (exec_pkg::DATA_W),
        .WRITE_MODE ("write_first")
    ) bank_a (
        .clk   (clk),
        .reset (reset),
        .en    (ram_en),
        .we    (wb.valid),
        .raddr (raddr_a),
        .waddr (wb.rd),
        .wdata (wb.data),
        .rdata (rdata_a)
    );

    sdpram #(
        .ADDR_WIDTH (exec_pkg::REG_ADDR_W),
        .DATA_WIDTH (exec_pkg::DATA_W),
        .WRITE_MODE ("write_first")
    ) bank_b (
        .clk   (clk),
        .reset (reset),
        .en    (ram_en),
        .we    (wb.valid),
        .raddr (raddr_b),
        .waddr (wb.rd),
        .wdata (wb.data),
        .rdata (rdata_b)
    );

    alu u_alu (
        .issue  (issue),
        .opnd_a (rdata_a),
        .opnd_b (rdata_b),
        .wb     (wb)
    );

    assign result = wb;   // the writeback is also the unit's output

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// free-running clock and a synchronous reset held for the first 3 rising edges
module tb_clock (
    output logic clk,
    output logic reset
);

    int unsigned reset_count = 0;   // rising edges seen so far

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    always @(posedge clk) begin
        if (reset_count < 3) begin
            reset_count <= reset_count + 1;
        end
    end

    assign reset = (reset_count < 3);   // drops just after the third edge

endmodule

`default_nettype wire

//--- reg_exec_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// timing rules of the slice seen from its ports
module reg_exec_unit_assertions (
    input wire logic          clk,
    input wire logic          reset,
    input wire logic          instr_valid,
    input wire exec_pkg::wb_t result
);

    // synchronous reset clears the execute record at the edge that samples it
    a_reset_clears: assert property (@(posedge clk) reset |=> !result.valid)
        else $error("result.valid high in the cycle after a reset edge");

    // an accepted word is on result exactly one cycle later
    // a word that meets a reset edge is dropped
    a_valid_follows: assert property (@(posedge clk)
        instr_valid && !reset |=> result.valid)
        else $error("accepted instruction gave no result one cycle later");

    // and nothing shows up without one
    a_no_spurious: assert property (@(posedge clk) !instr_valid |=> !result.valid)
        else $error("result.valid high without an instruction one cycle before");

    a_data_known: assert property (@(posedge clk) result.valid |-> !$isunknown(result.data))
        else $error("result.data has unknown bits while valid");

endmodule

bind reg_exec_unit reg_exec_unit_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .result      (result)
);

`default_nettype wire

//--- tb_reg_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reg_exec_unit;

    localparam int TEST_CYCLES     = 400;               // rough length of all tests
    localparam int WATCHDOG_CYCLES = 5 * TEST_CYCLES;
    localparam int NUM_REGS        = 1 << exec_pkg::REG_ADDR_W;
    localparam int RESET_CYCLES    = 3;                 // rising edges tb_clock holds reset

    logic                        clk;
    logic                        reset;
    logic                        instr_valid = 1'b0;
    exec_pkg::exec_instr_u       instr       = '0;
    exec_pkg::wb_t               result;
    logic [exec_pkg::DATA_W-1:0] regs [NUM_REGS];   // register model
    exec_pkg::wb_t               exp_next    = '0;  // expectation for the word being driven
    exec_pkg::wb_t               exp_cur;           // expectation for this cycle's result
    int                          checked     = 0;

    tb_clock u_clock (.clk(clk), .reset(reset));

    reg_exec_unit reg_exec_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [exec_pkg::REG_ADDR_W-1:0] rand_reg();
        logic [31:0] r;
        r = $urandom;
        return r[exec_pkg::REG_ADDR_W-1:0];
    endfunction

    function automatic logic [exec_pkg::IMM_W-1:0] rand_imm();
        logic [31:0] r;
        r = $urandom;
        return r[exec_pkg::IMM_W-1:0];
    endfunction

    // 18-bit two's complement widened to the data width
    function automatic logic [exec_pkg::DATA_W-1:0] sign_extend(
            input logic [exec_pkg::IMM_W-1:0] imm);
        logic [exec_pkg::DATA_W-1:0] value;
        value = {{(exec_pkg::DATA_W - exec_pkg::IMM_W){1'b0}}, imm};   // unsigned reading
        if (imm[exec_pkg::IMM_W-1]) begin
            value = value - (1 << exec_pkg::IMM_W);   // negative field is worth 2^18 less
        end
        return value;
    endfunction

    function automatic exec_pkg::exec_instr_u make_r(input exec_pkg::alu_op_e op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        exec_pkg::exec_instr_u w;
        logic [31:0]           r;
        r       = $urandom;
        w.r.op  = op;
        w.r.rd  = rd;
        w.r.rs1 = rs1;
        w.r.rs2 = rs2;
        w.r.pad = r[exec_pkg::R_PAD_W-1:0];   // random filler, must be ignored
        return w;
    endfunction

    function automatic exec_pkg::exec_instr_u make_i(input exec_pkg::alu_op_e op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [17:0] imm);
        exec_pkg::exec_instr_u w;
        w.i.op  = op;
        w.i.rd  = rd;
        w.i.rs1 = rs1;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic logic [31:0] expected_result(input logic [3:0] op,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
        case (op)
            exec_pkg::op_add:   return a + b;
            exec_pkg::op_sub:   return a - b;
            exec_pkg::op_and:   return a & b;
            exec_pkg::op_or:    return a | b;
            exec_pkg::op_xor:   return a ^ b;
            exec_pkg::op_addi:  return a + imm;
            exec_pkg::op_loadi: return imm;
            default:            return '0;   // unused codes write zero
        endcase
    endfunction

    // one instruction per call, back-to-back when called in a row
    task automatic send(input exec_pkg::exec_instr_u w);
        logic [31:0] res;
        res = expected_result(w.r.op, regs[w.r.rs1], regs[w.r.rs2], sign_extend(w.i.imm));
        @(posedge clk);
        instr_valid    <= 1'b1;
        instr          <= w;
        exp_next.valid <= 1'b1;
        exp_next.rd    <= w.r.rd;
        exp_next.data  <= res;
        regs[w.r.rd] = res;   // model sees the write before the next word is built
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid    <= 1'b0;
            instr          <= make_r(exec_pkg::op_add, rand_reg(), rand_reg(), rand_reg());
            exp_next.valid <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_cur <= '0;
        end else begin
            exp_cur <= exp_next;   // DUT takes the word at this same edge
        end
    end

    // result is stable in the middle of the cycle
    always @(negedge clk) begin
        assert (result.valid === exp_cur.valid)
            else stop_on_error($sformatf("mismatch at %0d ns: result.valid is %b, expected %b",
                                         $time, result.valid, exp_cur.valid));
        if (exp_cur.valid === 1'b1) begin
            assert (result.rd === exp_cur.rd)
                else stop_on_error($sformatf("mismatch at %0d ns: result.rd is %0d, expected %0d",
                                             $time, result.rd, exp_cur.rd));
            assert (result.data === exp_cur.data)
                else stop_on_error($sformatf("mismatch at %0d ns: register %0d got %h, expected %h",
                                             $time, exp_cur.rd, result.data, exp_cur.data));
            checked++;
        end
    end

    // words offered while reset is held must be dropped by the DUT
    task automatic check_reset_idle();
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= make_i(exec_pkg::op_loadi, rand_reg(), rand_reg(), rand_imm());
            @(negedge clk);
            assert (result.valid !== 1'b1)
                else stop_on_error($sformatf("mismatch at %0d ns: result.valid high in reset",
                                             $time));
        end
        idle(5);   // last offered word meets the final reset edge
    endtask

    task automatic load_and_read_back();
        for (int i = 0; i < NUM_REGS; i++) begin
            send(make_i(exec_pkg::op_loadi, i[4:0], rand_reg(), rand_imm()));
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            send(make_i(exec_pkg::op_addi, i[4:0], i[4:0], '0));   // plain readback
        end
        idle(1);
    endtask

    task automatic run_reg_reg_ops();
        exec_pkg::alu_op_e           op;
        logic [4:0]                  rs1;
        logic [2:0]                  pick;
        for (int n = 0; n < 60; n++) begin
            pick = 3'(n % 5);
            op   = exec_pkg::alu_op_e'({1'b0, pick});   // add through xor
            rs1  = rand_reg();
            send(make_r(op, rand_reg(), rs1, (n % 4 == 0) ? rs1 : rand_reg()));
        end
        idle(1);
    endtask

    // dependent word right behind its producer, served by the bank bypass
    task automatic run_back_to_back();
        logic [4:0] rd;
        logic [4:0] other;
        repeat (8) begin
            rd    = rand_reg();
            other = rand_reg();
            send(make_i(exec_pkg::op_loadi, rd, rand_reg(), rand_imm()));
            send(make_r(exec_pkg::op_add, rand_reg(), rd, other));   // port a
            send(make_i(exec_pkg::op_addi, rd, rd, rand_imm()));
            send(make_r(exec_pkg::op_sub, rand_reg(), other, rd));   // port b
            send(make_r(exec_pkg::op_add, rd, rd, rd));
            send(make_r(exec_pkg::op_xor, rand_reg(), rd, rd));      // both ports
            idle(1);
        end
    endtask

    task automatic check_sign_extension();
        send(make_i(exec_pkg::op_loadi, rand_reg(), rand_reg(), 18'h20000));   // most negative
        send(make_i(exec_pkg::op_loadi, rand_reg(), rand_reg(), 18'h3ffff));   // minus one
        repeat (12) begin
            send(make_i(exec_pkg::op_addi, rand_reg(), rand_reg(), rand_imm() | 18'h20000));
            send(make_i(exec_pkg::op_loadi, rand_reg(), rand_reg(), rand_imm() | 18'h20000));
        end
        idle(1);
    endtask

    task automatic run_gaps_and_unused();
        logic [4:0] rd;
        for (int gap = 1; gap <= 4; gap++) begin
            rd = rand_reg();
            send(make_i(exec_pkg::op_loadi, rd, rand_reg(), rand_imm()));
            idle(gap);
            send(make_r(exec_pkg::op_add, rand_reg(), rd, rd));
            idle(gap);
            send(make_r(exec_pkg::op_or, rand_reg(), rand_reg(), rd));
        end
        for (int code = 7; code < 16; code++) begin
            rd = rand_reg();
            send(make_r(exec_pkg::alu_op_e'(code[3:0]), rd, rand_reg(), rand_reg()));
            send(make_i(exec_pkg::op_addi, rand_reg(), rd, '0));   // zero comes back
            idle(1);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("timeout: tests still running after %0d cycles",
                                WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'hc60a));
        check_reset_idle();
        load_and_read_back();
        run_reg_reg_ops();
        run_back_to_back();
        check_sign_extension();
        run_gaps_and_unused();
        idle(3);   // last result drains
        $display("%0d results checked", checked);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- reg_exec_unit.f
exec_pkg.sv
sdpram.sv
issue_ctrl.sv
alu.sv
reg_exec_unit.sv
tb_clock.sv
reg_exec_unit_assertions.sv
tb_reg_exec_unit.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_reg_exec_unit
FILELIST   := reg_exec_unit.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(BINARY)
	./$(BINARY)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
